//--- logic/seq_pkg.sv
/* Step sequencer shared definitions: sizes, host register map,
   register word decoding, host write bus and configuration bundles */
package seq_pkg;

    // Array sizes and counter widths
    localparam int N_CHANNELS = 4;
    localparam int MAX_STEPS  = 8;
    localparam int CH_W       = 2;
    localparam int CNT_W      = 16;
    localparam int ADDR_W     = 5;
    localparam int STEP_W     = $clog2(MAX_STEPS);

    // Register map, word addresses
    localparam int REG_CONTROL    = 0;
    localparam int REG_DELAY      = 1;
    localparam int REG_STEP_BASE  = 2;
    localparam int REG_WIDTH_BASE = 10;
    // Fire counters are read-only
    localparam int REG_COUNT_BASE = 14;

    // Control word layout, n_steps in the low byte and burst at bit 8
    typedef struct packed {
        logic [22:0] pad;
        logic        burst;
        logic [7:0]  n_steps;
    } ctrl_word_t;

    // One host word, seen either as control fields or as a plain value
    typedef union packed {
        ctrl_word_t  ctrl;
        logic [31:0] value;
    } reg_word_u;

    // Host write bus, a write lands on every clock with strobe high
    typedef struct packed {
        logic              strobe;
        logic [ADDR_W-1:0] addr;
        reg_word_u         data;
    } reg_write_t;

    // Sequencer configuration as held by the register file
    typedef struct packed {
        logic [7:0]                      n_steps;
        logic                            burst;
        logic [CNT_W-1:0]                step_delay;
        logic [MAX_STEPS-1:0][CH_W-1:0]  step_table;
    } seq_config_t;

    typedef logic [N_CHANNELS-1:0][CNT_W-1:0] width_array_t;
    typedef logic [N_CHANNELS-1:0][CNT_W-1:0] count_array_t;

    // Sequencer FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_WAIT,
        ST_DELAY
    } seq_state_t;

endpackage

//--- logic/seq_regs.sv
/* Host register file: decodes write words into the sequencer configuration
   and channel widths, and serves combinational read-back including fire counts */
`timescale 1ns/1ps

module seq_regs (
    input  logic                         clock,
    input  logic                         rst_n,
    input  seq_pkg::reg_write_t          wr,
    input  logic [seq_pkg::ADDR_W-1:0]   rd_addr,
    output logic [31:0]                  rd_data,
    input  seq_pkg::count_array_t        counts,
    output seq_pkg::seq_config_t         cfg,
    output seq_pkg::width_array_t        widths
);

    // Read word is assembled through the same union used for writes
    seq_pkg::reg_word_u rd_word;

    // Writes outside the map and to the count window fall through every match
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg    <= '0;
            widths <= '0;
        end else if (wr.strobe) begin
            // Control is the only word decoded through the field view
            if (int'(wr.addr) == seq_pkg::REG_CONTROL) begin
                cfg.n_steps <= wr.data.ctrl.n_steps;
                cfg.burst   <= wr.data.ctrl.burst;
            end
            if (int'(wr.addr) == seq_pkg::REG_DELAY) begin
                cfg.step_delay <= wr.data.value[seq_pkg::CNT_W-1:0];
            end
            // Each step entry keeps only the channel index bits
            for (int i = 0; i < seq_pkg::MAX_STEPS; i++) begin
                if (int'(wr.addr) == seq_pkg::REG_STEP_BASE + i) begin
                    cfg.step_table[i] <= wr.data.value[seq_pkg::CH_W-1:0];
                end
            end
            for (int i = 0; i < seq_pkg::N_CHANNELS; i++) begin
                if (int'(wr.addr) == seq_pkg::REG_WIDTH_BASE + i) begin
                    widths[i] <= wr.data.value[seq_pkg::CNT_W-1:0];
                end
            end
        end
    end

    // Unused upper bits and unmapped addresses read as zero
    always_comb begin
        rd_word = '0;
        if (int'(rd_addr) == seq_pkg::REG_CONTROL) begin
            rd_word.ctrl.n_steps = cfg.n_steps;
            rd_word.ctrl.burst   = cfg.burst;
        end
        if (int'(rd_addr) == seq_pkg::REG_DELAY) begin
            rd_word.value[seq_pkg::CNT_W-1:0] = cfg.step_delay;
        end
        for (int i = 0; i < seq_pkg::MAX_STEPS; i++) begin
            if (int'(rd_addr) == seq_pkg::REG_STEP_BASE + i) begin
                rd_word.value[seq_pkg::CH_W-1:0] = cfg.step_table[i];
            end
        end
        for (int i = 0; i < seq_pkg::N_CHANNELS; i++) begin
            if (int'(rd_addr) == seq_pkg::REG_WIDTH_BASE + i) begin
                rd_word.value[seq_pkg::CNT_W-1:0] = widths[i];
            end
            // Counts come live from the gatherer
            if (int'(rd_addr) == seq_pkg::REG_COUNT_BASE + i) begin
                rd_word.value[seq_pkg::CNT_W-1:0] = counts[i];
            end
        end
    end

    assign rd_data = rd_word.value;

    // A control write never asks for more steps than the table holds
    a_n_steps_range: assert property (@(posedge clock) disable iff (!rst_n)
        (wr.strobe && int'(wr.addr) == seq_pkg::REG_CONTROL)
        |-> (int'(wr.data.ctrl.n_steps) <= seq_pkg::MAX_STEPS));

endmodule

//--- logic/step_sequencer.sv
/* Step sequencer FSM: walks the step table, fires one start strobe per step
   and spaces steps by the programmed delay after each channel reports done */
`timescale 1ns/1ps

module step_sequencer (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            enable,
    input  seq_pkg::seq_config_t            cfg,
    input  logic [seq_pkg::N_CHANNELS-1:0]  step_done,
    output logic [seq_pkg::N_CHANNELS-1:0]  start,
    output logic                            busy
);

    seq_pkg::seq_state_t             state;
    logic [seq_pkg::STEP_W-1:0]      step_idx;
    logic [seq_pkg::CNT_W-1:0]       delay_cnt;
    logic [seq_pkg::CH_W-1:0]        cur_ch;
    logic                            last_step;

    // Channel named by the table for the step in progress
    assign cur_ch = cfg.step_table[step_idx];

    // True on step n_steps-1, the comparison also stops a shrunken table early
    assign last_step = (8'(step_idx) + 8'd1) >= cfg.n_steps;

    assign busy = (state != seq_pkg::ST_IDLE);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= seq_pkg::ST_IDLE;
            step_idx  <= '0;
            delay_cnt <= '0;
            start     <= '0;
        end else begin
            // Start is a strobe, so it falls back to zero unless set below
            start <= '0;
            case (state)
                seq_pkg::ST_IDLE: begin
                    step_idx  <= '0;
                    delay_cnt <= '0;
                    // An empty table never leaves idle
                    if (enable && cfg.n_steps != 8'd0) begin
                        state <= seq_pkg::ST_START;
                    end
                end
                seq_pkg::ST_START: begin
                    start[cur_ch] <= 1'b1;
                    delay_cnt     <= '0;
                    state         <= seq_pkg::ST_WAIT;
                end
                seq_pkg::ST_WAIT: begin
                    // Only the done of the channel just started counts
                    if (step_done[cur_ch]) begin
                        state <= seq_pkg::ST_DELAY;
                    end
                end
                seq_pkg::ST_DELAY: begin
                    // Stays here step_delay+1 cycles
                    if (delay_cnt == cfg.step_delay) begin
                        delay_cnt <= '0;
                        if (last_step) begin
                            step_idx <= '0;
                            // Burst ends the run, continuous mode wraps without checking enable
                            state <= cfg.burst ? seq_pkg::ST_IDLE : seq_pkg::ST_START;
                        end else begin
                            step_idx <= step_idx + 1'b1;
                            state    <= seq_pkg::ST_START;
                        end
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= seq_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Any start is a single channel and lasts exactly one cycle
    a_start_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        (start != '0) |-> $onehot0(start) ##1 (start == '0));

endmodule

//--- logic/pulse_channel.sv
/* Timed output channel: a start strobe launches a high pulse of the
   programmed width, with done marking its last cycle */
`timescale 1ns/1ps

module pulse_channel (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [seq_pkg::CNT_W-1:0]   width,
    output logic                        pulse,
    output logic                        done
);

    // Cycles of pulse still to go, zero when idle
    logic [seq_pkg::CNT_W-1:0] remaining;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (remaining != '0) begin
            // A running pulse ignores further starts
            remaining <= remaining - 1'b1;
        end else if (start) begin
            // Zero width still gives a one-cycle pulse
            remaining <= (width == '0) ? {{(seq_pkg::CNT_W-1){1'b0}}, 1'b1} : width;
        end
    end

    assign pulse = (remaining != '0);
    assign done  = (remaining == {{(seq_pkg::CNT_W-1){1'b0}}, 1'b1});

    // Done falls in the last high cycle, so the pulse must drop right after it
    a_done_ends_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        done |-> pulse ##1 !pulse);

endmodule

//--- logic/done_gather.sv
/* Done gatherer: registers channel done strobes for the sequencer and
   keeps a wrapping fire counter per channel */
`timescale 1ns/1ps

module done_gather (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic [seq_pkg::N_CHANNELS-1:0]  done,
    output logic [seq_pkg::N_CHANNELS-1:0]  step_done,
    output seq_pkg::count_array_t           counts
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            step_done <= '0;
            counts    <= '0;
        end else begin
            // One cycle of delay between channel done and sequencer
            step_done <= done;
            // Count moves on the same edge that raises step_done
            for (int i = 0; i < seq_pkg::N_CHANNELS; i++) begin
                if (done[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/pulse_sequencer_top.sv
/* Pulse sequencer top: register file, step sequencer,
   channel array and done gatherer */
`timescale 1ns/1ps

module pulse_sequencer_top (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            enable,
    input  seq_pkg::reg_write_t             wr,
    input  logic [seq_pkg::ADDR_W-1:0]      rd_addr,
    output logic [31:0]                     rd_data,
    output logic [seq_pkg::N_CHANNELS-1:0]  pulses,
    output logic                            busy
);

    seq_pkg::seq_config_t               cfg;
    seq_pkg::width_array_t              widths;
    seq_pkg::count_array_t              counts;
    logic [seq_pkg::N_CHANNELS-1:0]     start;
    logic [seq_pkg::N_CHANNELS-1:0]     done;
    logic [seq_pkg::N_CHANNELS-1:0]     step_done;

    seq_regs u_regs (
        .clock   (clock),
        .rst_n   (rst_n),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .counts  (counts),
        .cfg     (cfg),
        .widths  (widths)
    );

    step_sequencer u_sequencer (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .cfg       (cfg),
        .step_done (step_done),
        .start     (start),
        .busy      (busy)
    );

    // One timed output per channel, each with its own width register
    for (genvar c = 0; c < seq_pkg::N_CHANNELS; c++) begin : g_channel
        pulse_channel u_channel (
            .clock (clock),
            .rst_n (rst_n),
            .start (start[c]),
            .width (widths[c]),
            .pulse (pulses[c]),
            .done  (done[c])
        );
    end

    done_gather u_gather (
        .clock     (clock),
        .rst_n     (rst_n),
        .done      (done),
        .step_done (step_done),
        .counts    (counts)
    );

endmodule

//--- tests/tb_pulse_sequencer.sv
/* Testbench for the pulse sequencer: replays the pattern file and checks
   register read-back, pulse order, widths, spacing and fire counts */
`timescale 1ns/1ps

module tb_pulse_sequencer;

    localparam int N_CASES    = 5;
    localparam int CASE_WORDS = 16;
    localparam int GAP_MAX    = 6;

    logic                            clock;
    logic                            rst_n;
    logic                            enable;
    seq_pkg::reg_write_t             wr;
    logic [seq_pkg::ADDR_W-1:0]      rd_addr;
    logic [31:0]                     rd_data;
    logic [seq_pkg::N_CHANNELS-1:0]  pulses;
    logic                            busy;

    // Sixteen words per case, laid out as the comment in the pattern file says
    logic [31:0] patterns [N_CASES*CASE_WORDS];

    // Case in progress, as the monitor sees it
    int cur_n;
    int cur_delay;
    int cur_table [seq_pkg::MAX_STEPS];
    int cur_widths [seq_pkg::N_CHANNELS];

    // Monitor state, updated on the falling edge only
    logic [seq_pkg::N_CHANNELS-1:0] prev_pulses;
    int  run_len [seq_pkg::N_CHANNELS];
    int  obs_counts [seq_pkg::N_CHANNELS];
    int  gap_cnt;
    bit  have_prev;
    int  case_pulses;
    int  cycle_cnt;
    int  cycle_limit;

    pulse_sequencer_top dut (
        .clock   (clock),
        .rst_n   (rst_n),
        .enable  (enable),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .pulses  (pulses),
        .busy    (busy)
    );

    always #4 clock = ~clock;

    // A zero width still gives one high cycle
    function automatic int expected_width(input int w);
        return (w == 0) ? 1 : w;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // One host write, strobe high for a single clock
    task automatic write_reg(input int addr, input logic [31:0] data);
        @(posedge clock);
        wr.strobe     <= 1'b1;
        wr.addr       <= addr[seq_pkg::ADDR_W-1:0];
        wr.data.value <= data;
        @(posedge clock);
        wr.strobe <= 1'b0;
    endtask

    // Read port is combinational, so the word is taken half a cycle later
    task automatic expect_reg(input int addr, input logic [31:0] exp, input string what);
        @(posedge clock);
        rd_addr <= addr[seq_pkg::ADDR_W-1:0];
        @(negedge clock);
        check_value(rd_data, exp, what);
    endtask

    // Watches every channel for order, width, overlap and spacing
    always @(negedge clock) begin
        if (rst_n) begin
            check_value(32'($countones(pulses) <= 1), 32'd1, "pulses overlap");
            for (int c = 0; c < seq_pkg::N_CHANNELS; c++) begin
                if (pulses[c]) begin
                    if (!prev_pulses[c]) begin
                        check_value(c, cur_table[case_pulses % cur_n], "channel order");
                        if (have_prev) begin
                            check_value(32'(gap_cnt >= cur_delay + 1), 32'd1, "gap too short");
                        end
                        run_len[c]    = 0;
                        obs_counts[c] = obs_counts[c] + 1;
                        case_pulses   = case_pulses + 1;
                        have_prev     = 1'b1;
                    end
                    run_len[c] = run_len[c] + 1;
                end else if (prev_pulses[c]) begin
                    check_value(run_len[c], expected_width(cur_widths[c]), "pulse width");
                    gap_cnt = 0;
                end
            end
            if (pulses == '0) begin
                gap_cnt = gap_cnt + 1;
            end
        end
        prev_pulses = pulses;
    end

    // Cycle budget guard
    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout after %0d cycles, the sequencer stopped making progress", cycle_cnt);
        end
    end

    initial begin
        int base;
        int n_steps;
        int burst;
        int delay;
        int reps;
        int target;
        int gap;
        clock       = 1'b0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        wr          = '0;
        rd_addr     = '0;
        prev_pulses = '0;
        gap_cnt     = 0;
        have_prev   = 1'b0;
        case_pulses = 0;
        cycle_cnt   = 0;
        cur_n       = 1;
        cur_delay   = 0;
        for (int c = 0; c < seq_pkg::N_CHANNELS; c++) begin
            run_len[c]    = 0;
            obs_counts[c] = 0;
            cur_widths[c] = 0;
        end
        for (int s = 0; s < seq_pkg::MAX_STEPS; s++) begin
            cur_table[s] = 0;
        end
        void'($urandom(32'he915b81c));
        $readmemh("tests/seq_patterns.hex", patterns);

        // Budget is steps times (width + delay + 8) plus register traffic and gaps
        cycle_limit = 4 + 40;
        for (int k = 0; k < N_CASES; k++) begin
            base = k * CASE_WORDS;
            for (int s = 0; s < int'(patterns[base]); s++) begin
                cycle_limit += int'(patterns[base+15]) * (int'(patterns[base+2]) + 8
                    + expected_width(int'(patterns[base+11+int'(patterns[base+3+s][1:0])])));
            end
            cycle_limit += 200 + GAP_MAX;
        end

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_value(pulses, 0, "pulses after reset");
        check_value(busy, 0, "busy after reset");
        for (int i = 0; i < seq_pkg::N_CHANNELS; i++) begin
            expect_reg(seq_pkg::REG_COUNT_BASE + i, 0, "count after reset");
        end

        for (int k = 0; k < N_CASES; k++) begin
            base    = k * CASE_WORDS;
            n_steps = int'(patterns[base]);
            burst   = int'(patterns[base+1]);
            delay   = int'(patterns[base+2]);
            reps    = int'(patterns[base+15]);

            // Program the whole map, then read every word back
            write_reg(seq_pkg::REG_CONTROL, 32'((burst << 8) | n_steps));
            write_reg(seq_pkg::REG_DELAY, patterns[base+2]);
            for (int s = 0; s < seq_pkg::MAX_STEPS; s++) begin
                write_reg(seq_pkg::REG_STEP_BASE + s, patterns[base+3+s]);
            end
            for (int c = 0; c < seq_pkg::N_CHANNELS; c++) begin
                write_reg(seq_pkg::REG_WIDTH_BASE + c, patterns[base+11+c]);
                write_reg(seq_pkg::REG_COUNT_BASE + c, 32'h0000_a5a5);
            end
            expect_reg(seq_pkg::REG_CONTROL, 32'((burst << 8) | n_steps), "control read-back");
            expect_reg(seq_pkg::REG_DELAY, patterns[base+2] & 32'hffff, "delay read-back");
            for (int s = 0; s < seq_pkg::MAX_STEPS; s++) begin
                expect_reg(seq_pkg::REG_STEP_BASE + s, patterns[base+3+s] & 32'h3, "step read-back");
            end
            for (int c = 0; c < seq_pkg::N_CHANNELS; c++) begin
                expect_reg(seq_pkg::REG_WIDTH_BASE + c, patterns[base+11+c] & 32'hffff,
                    "width read-back");
                expect_reg(seq_pkg::REG_COUNT_BASE + c, obs_counts[c], "count kept after write");
            end

            // Monitor view is switched only between clock rises
            @(posedge clock);
            cur_n       = n_steps;
            cur_delay   = delay;
            case_pulses = 0;
            have_prev   = 1'b0;
            for (int s = 0; s < seq_pkg::MAX_STEPS; s++) begin
                cur_table[s] = int'(patterns[base+3+s][1:0]);
            end
            for (int c = 0; c < seq_pkg::N_CHANNELS; c++) begin
                cur_widths[c] = int'(patterns[base+11+c][15:0]);
            end

            // Enable stays high just long enough for the FSM to leave idle
            enable <= 1'b1;
            do @(negedge clock); while (!busy);
            @(posedge clock);
            enable <= 1'b0;

            // Continuous mode only stops once burst is set during the last pass
            if (burst == 0) begin
                target = (reps - 1) * n_steps + 1;
                while (case_pulses < target) @(posedge clock);
                write_reg(seq_pkg::REG_CONTROL, 32'((1 << 8) | n_steps));
            end
            do @(negedge clock); while (busy);
            check_value(case_pulses, reps * n_steps, "pulses in sequence");
            for (int c = 0; c < seq_pkg::N_CHANNELS; c++) begin
                expect_reg(seq_pkg::REG_COUNT_BASE + c, obs_counts[c], "fire count");
            end

            gap = int'($urandom_range(GAP_MAX, 1));
            repeat (gap) @(posedge clock);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tests/seq_patterns.hex
// n_steps burst delay | step0 .. step7 channel | width0 .. width3 | repetitions
// Burst cases run the table once, continuous cases repeat it the given number of times
4 1 2   0 1 2 3 0 0 0 0   3 5 1 0   1
8 1 0   3 2 1 0 1 2 3 0   2 4 6 8   1
3 0 5   2 0 1 0 0 0 0 0   7 0 3 2   3
1 1 1   1 0 0 0 0 0 0 0   1 9 1 1   1
2 0 0   3 1 0 0 0 0 0 0   1 1 1 c   4

//--- vlog.f
logic/seq_pkg.sv
logic/seq_regs.sv
logic/step_sequencer.sv
logic/pulse_channel.sv
logic/done_gather.sv
logic/pulse_sequencer_top.sv
tests/tb_pulse_sequencer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the pulse sequencer testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || { echo "Cannot enter the project root"; exit 1; }

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pulse_sequencer -f vlog.f --Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_pulse_sequencer
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation finished with status 0"
exit 0
